//--- rs_pkg.sv
package rs_pkg;

    // station geometry
    localparam int NUM_RS_ENTRIES = 4;
    localparam int XLEN           = 32;
    localparam int ROB_TAG_WIDTH  = 4;

    // operand or result value
    typedef logic [XLEN-1:0] word_t;

    // producer or destination tag, 16 rob slots
    typedef logic [ROB_TAG_WIDTH-1:0] rob_tag_t;

    // one bit per entry
    typedef logic [NUM_RS_ENTRIES-1:0] rs_vec_t;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_XOR = 3'd4
    } alu_op_e;

    // entry life cycle
    typedef enum logic [1:0] {
        RS_FREE  = 2'd0,
        RS_WAIT  = 2'd1,
        RS_READY = 2'd2
    } rs_state_e;

endpackage

//--- rs_entry.sv
`timescale 1ns/1ns

module rs_entry import rs_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     alloc,
    input  logic     issue_done,
    input  alu_op_e  dispatch_op,
    input  rob_tag_t dispatch_dest_tag,
    input  rob_tag_t rs1_tag,
    input  logic     rs1_ready,
    input  word_t    rs1_value,
    input  rob_tag_t rs2_tag,
    input  logic     rs2_ready,
    input  word_t    rs2_value,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output logic     busy,
    output logic     ready,
    output alu_op_e  entry_op,
    output word_t    entry_value_a,
    output word_t    entry_value_b,
    output rob_tag_t entry_dest_tag
);

    rs_state_e state_q;
    rs_state_e state_d;

    logic      src_a_valid_q;
    logic      src_b_valid_q;
    logic      src_a_valid_d;
    logic      src_b_valid_d;
    rob_tag_t  src_a_tag_q;
    rob_tag_t  src_b_tag_q;

    alu_op_e   op_q;
    rob_tag_t  dest_tag_q;
    word_t     value_a_q;
    word_t     value_b_q;

    logic      fwd_a;
    logic      fwd_b;
    logic      snoop_a;
    logic      snoop_b;

    // broadcast in the dispatch cycle
    assign fwd_a = cdb_valid && (cdb_tag == rs1_tag);
    assign fwd_b = cdb_valid && (cdb_tag == rs2_tag);

    // pending operand picked off the cdb
    assign snoop_a = (state_q == RS_WAIT) && !src_a_valid_q &&
                     cdb_valid && (cdb_tag == src_a_tag_q);
    assign snoop_b = (state_q == RS_WAIT) && !src_b_valid_q &&
                     cdb_valid && (cdb_tag == src_b_tag_q);

    always_comb begin
        state_d       = state_q;
        src_a_valid_d = src_a_valid_q;
        src_b_valid_d = src_b_valid_q;

        if (alloc) begin
            src_a_valid_d = rs1_ready || fwd_a;
            src_b_valid_d = rs2_ready || fwd_b;
        end else begin
            if (snoop_a) begin
                src_a_valid_d = 1'b1;
            end
            if (snoop_b) begin
                src_b_valid_d = 1'b1;
            end
        end

        if (flush || issue_done) begin
            state_d = RS_FREE;
        end else if (alloc || (state_q == RS_WAIT)) begin
            state_d = (src_a_valid_d && src_b_valid_d) ? RS_READY : RS_WAIT;
        end
    end

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            state_q       <= RS_FREE;
            src_a_valid_q <= 1'b0;
            src_b_valid_q <= 1'b0;
        end else begin
            state_q       <= state_d;
            src_a_valid_q <= src_a_valid_d;
            src_b_valid_q <= src_b_valid_d;
        end
    end

    always_ff @(posedge clock) begin
        if (alloc) begin
            op_q        <= dispatch_op;
            dest_tag_q  <= dispatch_dest_tag;
            src_a_tag_q <= rs1_tag;
            src_b_tag_q <= rs2_tag;
            // a ready source wins over a forwarded one
            value_a_q   <= rs1_ready ? rs1_value : cdb_value;
            value_b_q   <= rs2_ready ? rs2_value : cdb_value;
        end else begin
            if (snoop_a) begin
                value_a_q <= cdb_value;
            end
            if (snoop_b) begin
                value_b_q <= cdb_value;
            end
        end
    end

    assign busy           = (state_q != RS_FREE);
    assign ready          = (state_q == RS_READY);
    assign entry_op       = op_q;
    assign entry_value_a  = value_a_q;
    assign entry_value_b  = value_b_q;
    assign entry_dest_tag = dest_tag_q;

    // allocator must only pick a free entry
    alloc_when_free: assert property (@(posedge clock) disable iff (!rst_n)
        alloc |-> !busy);

    // selector must only grant a ready entry
    done_when_ready: assert property (@(posedge clock) disable iff (!rst_n)
        issue_done |-> ready);

endmodule

//--- rs_alloc.sv
`timescale 1ns/1ns

module rs_alloc import rs_pkg::*; (
    input  logic    dispatch_valid,
    input  rs_vec_t entry_busy,
    output rs_vec_t alloc,
    output logic    dispatch_stall
);

    rs_vec_t free_vec;

    assign free_vec = ~entry_busy;

    // lowest index free entry wins
    always_comb begin
        logic found;
        found = 1'b0;
        alloc = '0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            if (free_vec[i] && !found) begin
                alloc[i] = dispatch_valid;
                found    = 1'b1;
            end
        end
    end

    // no room left
    assign dispatch_stall = ~|free_vec;

    // at most one entry per dispatch
    always_comb begin
        alloc_onehot: assert final ($onehot0(alloc));
    end

endmodule

//--- rs_issue_select.sv
`timescale 1ns/1ns

module rs_issue_select import rs_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  rs_vec_t  alloc,
    input  rs_vec_t  entry_busy,
    input  rs_vec_t  entry_ready,
    input  alu_op_e  entry_op [NUM_RS_ENTRIES],
    input  word_t    entry_value_a [NUM_RS_ENTRIES],
    input  word_t    entry_value_b [NUM_RS_ENTRIES],
    input  rob_tag_t entry_dest_tag [NUM_RS_ENTRIES],
    input  logic     issue_ack,
    output rs_vec_t  issue_done,
    output logic     issue_valid,
    output alu_op_e  issue_op,
    output word_t    issue_value_a,
    output word_t    issue_value_b,
    output rob_tag_t issue_dest_tag
);

    // older_q[i][j] set when entry j is older than entry i
    rs_vec_t older_q [NUM_RS_ENTRIES];

    rs_vec_t oldest_ready;
    rs_vec_t grant;
    rs_vec_t hold_grant_q;
    logic    hold_q;

    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
                older_q[i] <= '0;
            end
        end else if (flush) begin
            for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
                older_q[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
                if (alloc[i]) begin
                    // new entry is younger than everything in flight
                    older_q[i] <= entry_busy;
                end else begin
                    for (int j = 0; j < NUM_RS_ENTRIES; j++) begin
                        if (alloc[j]) begin
                            older_q[i][j] <= 1'b0;
                        end
                    end
                end
            end
        end
    end

    // ready entry with no older ready entry
    always_comb begin
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            oldest_ready[i] = entry_ready[i] && !(|(older_q[i] & entry_ready));
        end
    end

    // keep the grant steady while the unit stalls
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            hold_q       <= 1'b0;
            hold_grant_q <= '0;
        end else begin
            hold_q       <= issue_valid && !issue_ack && !flush;
            hold_grant_q <= grant;
        end
    end

    assign grant       = hold_q ? hold_grant_q : oldest_ready;
    assign issue_valid = |grant;
    assign issue_done  = grant & {NUM_RS_ENTRIES{issue_ack}};

    always_comb begin
        issue_op       = ALU_ADD;
        issue_value_a  = '0;
        issue_value_b  = '0;
        issue_dest_tag = '0;
        for (int i = 0; i < NUM_RS_ENTRIES; i++) begin
            if (grant[i]) begin
                issue_op       = entry_op[i];
                issue_value_a  = entry_value_a[i];
                issue_value_b  = entry_value_b[i];
                issue_dest_tag = entry_dest_tag[i];
            end
        end
    end

    grant_onehot: assert property (@(posedge clock) disable iff (!rst_n)
        $onehot0(grant));

    // back-pressure holds the issue payload
    payload_stable: assert property (@(posedge clock) disable iff (!rst_n)
        issue_valid && !issue_ack && !flush |=>
            issue_valid && $stable(issue_op) && $stable(issue_value_a) &&
            $stable(issue_value_b) && $stable(issue_dest_tag));

endmodule

//--- reservation_station.sv
`timescale 1ns/1ns

module reservation_station import rs_pkg::*; (
    input  logic     clock,
    input  logic     rst_n,
    input  logic     flush,
    input  logic     dispatch_valid,
    input  alu_op_e  dispatch_op,
    input  rob_tag_t dispatch_dest_tag,
    input  rob_tag_t rs1_tag,
    input  logic     rs1_ready,
    input  word_t    rs1_value,
    input  rob_tag_t rs2_tag,
    input  logic     rs2_ready,
    input  word_t    rs2_value,
    output logic     dispatch_stall,
    input  logic     cdb_valid,
    input  rob_tag_t cdb_tag,
    input  word_t    cdb_value,
    output logic     issue_valid,
    output alu_op_e  issue_op,
    output word_t    issue_value_a,
    output word_t    issue_value_b,
    output rob_tag_t issue_dest_tag,
    input  logic     issue_ack
);

    rs_vec_t  alloc;
    rs_vec_t  issue_done;
    rs_vec_t  entry_busy;
    rs_vec_t  entry_ready;
    alu_op_e  entry_op [NUM_RS_ENTRIES];
    word_t    entry_value_a [NUM_RS_ENTRIES];
    word_t    entry_value_b [NUM_RS_ENTRIES];
    rob_tag_t entry_dest_tag [NUM_RS_ENTRIES];

    rs_alloc rs_alloc_i (
        .dispatch_valid (dispatch_valid),
        .entry_busy     (entry_busy),
        .alloc          (alloc),
        .dispatch_stall (dispatch_stall)
    );

    for (genvar i = 0; i < NUM_RS_ENTRIES; i++) begin : g_entry
        rs_entry rs_entry_i (
            .clock             (clock),
            .rst_n             (rst_n),
            .flush             (flush),
            .alloc             (alloc[i]),
            .issue_done        (issue_done[i]),
            .dispatch_op       (dispatch_op),
            .dispatch_dest_tag (dispatch_dest_tag),
            .rs1_tag           (rs1_tag),
            .rs1_ready         (rs1_ready),
            .rs1_value         (rs1_value),
            .rs2_tag           (rs2_tag),
            .rs2_ready         (rs2_ready),
            .rs2_value         (rs2_value),
            .cdb_valid         (cdb_valid),
            .cdb_tag           (cdb_tag),
            .cdb_value         (cdb_value),
            .busy              (entry_busy[i]),
            .ready             (entry_ready[i]),
            .entry_op          (entry_op[i]),
            .entry_value_a     (entry_value_a[i]),
            .entry_value_b     (entry_value_b[i]),
            .entry_dest_tag    (entry_dest_tag[i])
        );
    end

    rs_issue_select rs_issue_select_i (
        .clock          (clock),
        .rst_n          (rst_n),
        .flush          (flush),
        .alloc          (alloc),
        .entry_busy     (entry_busy),
        .entry_ready    (entry_ready),
        .entry_op       (entry_op),
        .entry_value_a  (entry_value_a),
        .entry_value_b  (entry_value_b),
        .entry_dest_tag (entry_dest_tag),
        .issue_ack      (issue_ack),
        .issue_done     (issue_done),
        .issue_valid    (issue_valid),
        .issue_op       (issue_op),
        .issue_value_a  (issue_value_a),
        .issue_value_b  (issue_value_b),
        .issue_dest_tag (issue_dest_tag)
    );

endmodule

//--- tb_rs.sv
`timescale 1ns/1ns

module tb_rs import rs_pkg::*; ();

    localparam int CLK_PERIOD      = 8;
    localparam int NUM_TESTS       = 6;
    localparam int CYCLES_PER_TEST = 200;
    localparam int WATCHDOG_NS     = NUM_TESTS * CYCLES_PER_TEST * CLK_PERIOD;

    logic     clock;
    logic     rst_n;
    logic     flush;
    logic     dispatch_valid;
    alu_op_e  dispatch_op;
    rob_tag_t dispatch_dest_tag;
    rob_tag_t rs1_tag;
    logic     rs1_ready;
    word_t    rs1_value;
    rob_tag_t rs2_tag;
    logic     rs2_ready;
    word_t    rs2_value;
    logic     dispatch_stall;
    logic     cdb_valid;
    rob_tag_t cdb_tag;
    word_t    cdb_value;
    logic     issue_valid;
    alu_op_e  issue_op;
    word_t    issue_value_a;
    word_t    issue_value_b;
    rob_tag_t issue_dest_tag;
    logic     issue_ack;

    int       errors;
    string    test_name;

    // expected instruction slots
    alu_op_e  exp_op  [8];
    word_t    exp_a   [8];
    word_t    exp_b   [8];
    rob_tag_t exp_tag [8];

    reservation_station reservation_station_i (.*);

    initial begin
        clock = 1'b0;
        forever #(CLK_PERIOD / 2) clock = ~clock;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("run timed out after %0d ns, errors so far: %0d", WATCHDOG_NS, errors);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic step();
        @(posedge clock);
        #1;
    endtask

    task automatic check_word(input string what, input word_t exp, input word_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %h, actual %h", test_name, what, exp, act);
        end
    endtask

    task automatic check_tag(input string what, input rob_tag_t exp, input rob_tag_t act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %0d, actual %0d", test_name, what, exp, act);
        end
    endtask

    task automatic check_op(input string what, input alu_op_e exp, input alu_op_e act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %s, actual %s", test_name, what,
                     exp.name(), act.name());
        end
    endtask

    task automatic check_bit(input string what, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("FAILED %s %s: expected %b, actual %b", test_name, what, exp, act);
        end
    endtask

    task automatic make_instr(input int idx);
        exp_op[idx]  = alu_op_e'($urandom_range(4, 0));
        exp_a[idx]   = $urandom;
        exp_b[idx]   = $urandom;
        exp_tag[idx] = rob_tag_t'($urandom);
    endtask

    // a waiting source carries a wrong value so a bad capture shows up
    task automatic dispatch_instr(input int idx, input logic r1, input rob_tag_t t1,
                                  input logic r2, input rob_tag_t t2);
        dispatch_valid    = 1'b1;
        dispatch_op       = exp_op[idx];
        dispatch_dest_tag = exp_tag[idx];
        rs1_ready         = r1;
        rs1_tag           = t1;
        rs1_value         = r1 ? exp_a[idx] : ~exp_a[idx];
        rs2_ready         = r2;
        rs2_tag           = t2;
        rs2_value         = r2 ? exp_b[idx] : ~exp_b[idx];
        step();
        dispatch_valid = 1'b0;
    endtask

    task automatic broadcast(input rob_tag_t tag, input word_t value);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = value;
        step();
        cdb_valid = 1'b0;
    endtask

    task automatic issue_one(input int idx);
        check_bit("issue_valid", 1'b1, issue_valid);
        check_op("issue_op", exp_op[idx], issue_op);
        check_word("issue_value_a", exp_a[idx], issue_value_a);
        check_word("issue_value_b", exp_b[idx], issue_value_b);
        check_tag("issue_dest_tag", exp_tag[idx], issue_dest_tag);
        issue_ack = 1'b1;
        step();
        issue_ack = 1'b0;
    endtask

    task automatic test_reset();
        test_name = "reset";
        check_bit("dispatch_stall", 1'b0, dispatch_stall);
        check_bit("issue_valid", 1'b0, issue_valid);
    endtask

    task automatic test_ready_dispatch();
        test_name = "ready_dispatch";
        make_instr(0);
        check_bit("issue_valid before", 1'b0, issue_valid);
        dispatch_instr(0, 1'b1, rob_tag_t'($urandom), 1'b1, rob_tag_t'($urandom));
        issue_one(0);
        check_bit("issue_valid after ack", 1'b0, issue_valid);
    endtask

    task automatic test_cdb_wakeup();
        rob_tag_t tag;
        test_name = "cdb_wakeup";
        tag = rob_tag_t'($urandom);
        make_instr(0);
        dispatch_instr(0, 1'b0, tag, 1'b1, rob_tag_t'($urandom));
        check_bit("issue_valid waiting", 1'b0, issue_valid);
        broadcast(tag ^ 4'h1, ~exp_a[0]);
        check_bit("issue_valid other tag", 1'b0, issue_valid);
        cdb_tag   = tag;
        cdb_value = ~exp_a[0];
        step();
        check_bit("issue_valid cdb_valid low", 1'b0, issue_valid);
        broadcast(tag, exp_a[0]);
        issue_one(0);

        // broadcast lands in the dispatch cycle
        make_instr(1);
        tag       = rob_tag_t'($urandom);
        cdb_valid = 1'b1;
        cdb_tag   = tag;
        cdb_value = exp_b[1];
        dispatch_instr(1, 1'b1, rob_tag_t'($urandom), 1'b0, tag);
        cdb_valid = 1'b0;
        issue_one(1);
        check_bit("issue_valid after ack", 1'b0, issue_valid);
    endtask

    task automatic test_full_station();
        rob_tag_t base;
        test_name = "full_station";
        base = rob_tag_t'($urandom);
        for (int i = 0; i < 4; i++) begin
            make_instr(i);
            check_bit("dispatch_stall filling", 1'b0, dispatch_stall);
            dispatch_instr(i, 1'b0, base + rob_tag_t'(i), 1'b1, '0);
        end
        check_bit("dispatch_stall full", 1'b1, dispatch_stall);
        check_bit("issue_valid full", 1'b0, issue_valid);
        // fifth dispatch must be dropped
        make_instr(4);
        dispatch_instr(4, 1'b1, '0, 1'b1, '0);
        check_bit("dispatch_stall fifth", 1'b1, dispatch_stall);
        check_bit("issue_valid fifth", 1'b0, issue_valid);
        broadcast(base + rob_tag_t'(2), exp_a[2]);
        issue_one(2);
        check_bit("dispatch_stall freed", 1'b0, dispatch_stall);
        make_instr(5);
        dispatch_instr(5, 1'b1, '0, 1'b1, '0);
        check_bit("dispatch_stall refilled", 1'b1, dispatch_stall);
        issue_one(5);
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_bit("dispatch_stall drained", 1'b0, dispatch_stall);
    endtask

    task automatic test_oldest_first();
        rob_tag_t tag;
        test_name = "oldest_first";
        tag = rob_tag_t'($urandom);
        for (int i = 0; i < 4; i++) begin
            make_instr(i);
        end
        // oldest entry waits on the cdb
        dispatch_instr(0, 1'b0, tag, 1'b1, rob_tag_t'($urandom));
        for (int i = 1; i < 3; i++) begin
            dispatch_instr(i, 1'b1, rob_tag_t'($urandom), 1'b1, rob_tag_t'($urandom));
        end
        // waking the older entry must not move a stalled issue
        for (int n = 0; n < 4; n++) begin
            check_bit("issue_valid held", 1'b1, issue_valid);
            check_op("issue_op held", exp_op[1], issue_op);
            check_word("issue_value_a held", exp_a[1], issue_value_a);
            check_word("issue_value_b held", exp_b[1], issue_value_b);
            check_tag("issue_dest_tag held", exp_tag[1], issue_dest_tag);
            if (n == 1) begin
                broadcast(tag, exp_a[0]);
            end else begin
                step();
            end
        end
        issue_one(1);
        issue_one(0);
        // entry 0 now holds the youngest
        dispatch_instr(3, 1'b1, rob_tag_t'($urandom), 1'b1, rob_tag_t'($urandom));
        issue_one(2);
        issue_one(3);
        check_bit("issue_valid drained", 1'b0, issue_valid);
    endtask

    task automatic test_flush();
        rob_tag_t base;
        test_name = "flush";
        base = rob_tag_t'($urandom);
        for (int i = 0; i < 4; i++) begin
            make_instr(i);
            dispatch_instr(i, 1'b0, base + rob_tag_t'(i), 1'b0, base + rob_tag_t'(i));
        end
        check_bit("dispatch_stall pending", 1'b1, dispatch_stall);
        flush = 1'b1;
        step();
        flush = 1'b0;
        check_bit("dispatch_stall flushed", 1'b0, dispatch_stall);
        for (int i = 0; i < 4; i++) begin
            broadcast(base + rob_tag_t'(i), $urandom);
            check_bit("issue_valid flushed", 1'b0, issue_valid);
        end
        for (int i = 0; i < 4; i++) begin
            make_instr(i);
            check_bit("dispatch_stall refill", 1'b0, dispatch_stall);
            dispatch_instr(i, 1'b1, '0, 1'b1, '0);
        end
        check_bit("dispatch_stall refilled", 1'b1, dispatch_stall);
        for (int i = 0; i < 4; i++) begin
            issue_one(i);
        end
        check_bit("issue_valid drained", 1'b0, issue_valid);
    endtask

    initial begin
        void'($urandom(75));
        errors            = 0;
        test_name         = "init";
        rst_n             = 1'b0;
        flush             = 1'b0;
        dispatch_valid    = 1'b0;
        dispatch_op       = ALU_ADD;
        dispatch_dest_tag = '0;
        rs1_tag           = '0;
        rs1_ready         = 1'b0;
        rs1_value         = '0;
        rs2_tag           = '0;
        rs2_ready         = 1'b0;
        rs2_value         = '0;
        cdb_valid         = 1'b0;
        cdb_tag           = '0;
        cdb_value         = '0;
        issue_ack         = 1'b0;

        repeat (16) @(posedge clock);
        #1;
        rst_n = 1'b1;
        step();

        test_reset();
        test_ready_dispatch();
        test_cdb_wakeup();
        test_full_station();
        test_oldest_first();
        test_flush();

        $display("errors: %0d", errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

//--- build.f
rs_pkg.sv
rs_entry.sv
rs_alloc.sv
rs_issue_select.sv
reservation_station.sv
tb_rs.sv

//--- Bender.yml
package:
  name: reservation_station

sources:
  - rs_pkg.sv
  - rs_entry.sv
  - rs_alloc.sv
  - rs_issue_select.sv
  - reservation_station.sv
  - target: simulation
    files:
      - tb_rs.sv
